// ==== verilog/lcd_cfg.svh ====
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// timebase, clock cycles per microsecond
`define LCD_CLK_PER_US     20

`define LCD_POWERUP_US     500
`define LCD_STEP_PULSE_US  10
`define LCD_WAIT_SET_US    50
`define LCD_WAIT_CLEAR_US  200
`define LCD_WAIT_ENTRY_US  100

`define LCD_CMD_US         50
`define LCD_E_RISE_US      1
`define LCD_E_FALL_US      14

`define LCD_FIFO_DEPTH     8

`define LCD_ADDR_CTRL      4'h0
`define LCD_ADDR_CMD       4'h4
`define LCD_ADDR_STATUS    4'h8
`define LCD_ADDR_RDATA     4'hC
`endif

// ==== verilog/lcd_pkg.sv ====
`default_nettype none

`include "lcd_cfg.svh"

package lcd_pkg;

	localparam int LCD_LVL_W = $clog2(`LCD_FIFO_DEPTH + 1);	// fill level width

	typedef struct packed {
		logic       rs;	// 1 = data register
		logic       rw;	// 1 = read from panel
		logic [7:0] data;
	} lcd_cmd_t;

	typedef struct packed {
		logic lines;		// 2-line display
		logic font;		// 5x10 font
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;		// address increment
		logic shift;		// display shift on write
	} lcd_init_cfg_t;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	typedef struct packed {
		logic                 busy;
		logic                 init_done;
		logic                 fifo_empty;
		logic                 fifo_full;
		logic                 overflow;	// sticky, cleared on status read
		logic [LCD_LVL_W-1:0] level;
	} lcd_status_t;

	typedef enum logic [2:0] {
		POWERUP,
		WAIT_CFG,
		INIT,
		IDLE,
		CMD
	} lcd_state_e;

endpackage

`default_nettype wire

// ==== verilog/lcd_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_cmd_fifo
	import lcd_pkg::*;
#(
	parameter int DEPTH = `LCD_FIFO_DEPTH
) (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	input  wire logic                       push,
	input  wire lcd_cmd_t                   push_data,
	input  wire logic                       pop,
	output lcd_cmd_t                        head,
	output logic                            empty,
	output logic                            full,
	output logic [$clog2(DEPTH + 1) - 1:0] level
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	lcd_cmd_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;	// wrap for non power of two depth
		return p + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (level == '0);
	assign full  = (level == ($bits(level))'(DEPTH));
	assign head  = mem[rd_ptr];	// show-ahead

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;	// both or neither
			endcase
		end
	end

	// engine only pops a word that is there
	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> !empty);

endmodule

`default_nettype wire

// ==== verilog/lcd_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_apb_regs
	import lcd_pkg::*;
(
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire logic [3:0]           paddr,
	input  wire logic                 psel,
	input  wire logic                 penable,
	input  wire logic                 pwrite,
	input  wire logic [31:0]          pwdata,
	output logic      [31:0]          prdata,
	output logic                      pready,
	output logic                      pslverr,
	output lcd_init_cfg_t             init_cfg,
	output logic                      init_start,
	output logic                      push,
	output lcd_cmd_t                  push_data,
	input  wire logic                 fifo_full,
	input  wire logic [LCD_LVL_W-1:0] fifo_level,
	input  wire logic                 busy,
	input  wire logic                 init_done,
	input  wire logic                 rdata_valid,
	input  wire logic [7:0]           rdata
);

	logic          access;
	logic          wr;
	logic          rd;
	logic          mapped;
	logic          ctrl_wr;
	logic          cmd_wr;
	logic          status_rd;
	lcd_init_cfg_t cfg_q;
	logic          overflow_q;
	logic [7:0]    rdata_q;
	lcd_status_t   status;

	assign access = psel && penable;	// access phase, zero wait states
	assign wr     = access && pwrite;
	assign rd     = access && !pwrite;

	assign mapped = (paddr == `LCD_ADDR_CTRL) || (paddr == `LCD_ADDR_CMD) ||
	                (paddr == `LCD_ADDR_STATUS) || (paddr == `LCD_ADDR_RDATA);

	assign ctrl_wr   = wr && (paddr == `LCD_ADDR_CTRL);
	assign cmd_wr    = wr && (paddr == `LCD_ADDR_CMD);
	assign status_rd = rd && (paddr == `LCD_ADDR_STATUS);

	// engine is only free for a new init in WAIT_CFG or IDLE
	assign init_start = ctrl_wr && !busy;

	// new config reaches the engine on the same edge as init_start
	assign init_cfg = init_start ? lcd_init_cfg_t'(pwdata[6:0]) : cfg_q;

	assign push      = cmd_wr && !fifo_full;
	assign push_data = lcd_cmd_t'(pwdata[9:0]);

	assign pready  = 1'b1;
	assign pslverr = access && (!mapped || (ctrl_wr && busy) || (cmd_wr && fifo_full));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q      <= '0;
			overflow_q <= 1'b0;
			rdata_q    <= '0;
		end else begin
			if (init_start)
				cfg_q <= init_cfg;
			if (cmd_wr && fifo_full)
				overflow_q <= 1'b1;	// dropped word
			else if (status_rd)
				overflow_q <= 1'b0;
			if (rdata_valid)
				rdata_q <= rdata;	// last byte read from the panel
		end
	end

	always_comb begin
		status.busy       = busy;
		status.init_done  = init_done;
		status.fifo_empty = (fifo_level == '0);
		status.fifo_full  = fifo_full;
		status.overflow   = overflow_q;
		status.level      = fifo_level;
	end

	always_comb begin
		prdata = '0;
		if (rd) begin
			case (paddr)
				`LCD_ADDR_CTRL:   prdata = {25'd0, cfg_q};
				`LCD_ADDR_STATUS: prdata = 32'(status);
				`LCD_ADDR_RDATA:  prdata = {24'd0, rdata_q};
				default:          prdata = '0;	// CMD is write-only
			endcase
		end
	end

	// the FIFO never sees a push it cannot hold
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> fifo_level < LCD_LVL_W'(`LCD_FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== verilog/lcd_timing_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_timing_engine
	import lcd_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          arst_n,
	input  wire lcd_init_cfg_t init_cfg,
	input  wire logic          init_start,
	input  wire logic          empty,
	output logic               pop,
	input  wire lcd_cmd_t      head,
	output lcd_pins_t          pins,
	input  wire logic [7:0]    lcd_data_in,
	output logic               busy,
	output logic               init_done,
	output logic               rdata_valid,
	output logic [7:0]         rdata
);

	localparam int unsigned T           = `LCD_CLK_PER_US;
	localparam int unsigned POWERUP_CYC = `LCD_POWERUP_US * T;
	localparam int unsigned PULSE_CYC   = `LCD_STEP_PULSE_US * T;
	localparam int unsigned SLOT_CYC    = `LCD_CMD_US * T;
	localparam int unsigned E_RISE_CYC  = `LCD_E_RISE_US * T;
	localparam int unsigned E_FALL_CYC  = `LCD_E_FALL_US * T;
	localparam int          CNT_W       = $clog2(POWERUP_CYC);	// longest wait

	lcd_state_e       state_q;
	lcd_state_e       state_d;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] cnt_d;
	logic [1:0]       step_q;
	logic [1:0]       step_d;
	lcd_cmd_t         cmd_q;
	lcd_cmd_t         cmd_d;
	lcd_pins_t        pins_d;
	logic             sample;

	// pulse plus settle time of one init step
	function automatic logic [CNT_W-1:0] step_len(input logic [1:0] s);
		logic [CNT_W-1:0] wait_cyc;
		case (s)
			2'd0, 2'd1: wait_cyc = CNT_W'(`LCD_WAIT_SET_US * T);
			2'd2:       wait_cyc = CNT_W'(`LCD_WAIT_CLEAR_US * T);
			default:    wait_cyc = CNT_W'(`LCD_WAIT_ENTRY_US * T);
		endcase
		return CNT_W'(PULSE_CYC) + wait_cyc;
	endfunction

	function automatic logic [7:0] step_byte(input logic [1:0] s, input lcd_init_cfg_t c);
		logic [7:0] b;
		case (s)
			2'd0:    b = {4'b0011, c.lines, c.font, 2'b00};	// function set
			2'd1:    b = {5'b00001, c.display_on, c.cursor, c.blink};
			2'd2:    b = 8'h01;	// clear
			default: b = {6'b000001, c.inc_dec, c.shift};	// entry mode
		endcase
		return b;
	endfunction

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q + 1'b1;
		step_d  = step_q;
		cmd_d   = cmd_q;
		pop     = 1'b0;
		case (state_q)
			POWERUP: begin
				if (cnt_q == CNT_W'(POWERUP_CYC - 1)) begin
					state_d = WAIT_CFG;
					cnt_d   = '0;
				end
			end
			WAIT_CFG: begin
				cnt_d = '0;
				if (init_start) begin
					state_d = INIT;
					step_d  = 2'd0;
				end
			end
			INIT: begin
				if (cnt_q == step_len(step_q) - 1'b1) begin
					cnt_d = '0;
					if (step_q == 2'd3)
						state_d = IDLE;
					else
						step_d = step_q + 1'b1;
				end
			end
			IDLE: begin
				cnt_d = '0;
				if (init_start) begin	// re-init wins over queued words
					state_d = INIT;
					step_d  = 2'd0;
				end else if (!empty) begin
					pop     = 1'b1;
					cmd_d   = head;
					state_d = CMD;
				end
			end
			CMD: begin
				if (cnt_q == CNT_W'(SLOT_CYC - 1)) begin
					state_d = IDLE;
					cnt_d   = '0;
				end
			end
			default: begin
				state_d = POWERUP;
				cnt_d   = '0;
			end
		endcase
	end

	// pins follow the next state so the registered outputs line up with it
	always_comb begin
		pins_d = '0;
		case (state_d)
			INIT: begin
				if (cnt_d < CNT_W'(PULSE_CYC)) begin
					pins_d.e    = 1'b1;
					pins_d.data = step_byte(step_d, init_cfg);
				end
			end
			CMD: begin
				pins_d.rs   = cmd_d.rs;
				pins_d.rw   = cmd_d.rw;
				pins_d.data = cmd_d.data;
				pins_d.e    = (cnt_d >= CNT_W'(E_RISE_CYC)) && (cnt_d < CNT_W'(E_FALL_CYC));
			end
			default: pins_d = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= POWERUP;
			cnt_q   <= '0;
			step_q  <= '0;
			pins    <= '0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			step_q  <= step_d;
			pins    <= pins_d;
		end
	end

	always_ff @(posedge clk) begin
		cmd_q <= cmd_d;	// word held for the slot
	end

	// last cycle with e high
	assign sample = (state_q == CMD) && cmd_q.rw && (cnt_q == CNT_W'(E_FALL_CYC - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rdata_valid <= 1'b0;
		else
			rdata_valid <= sample;
	end

	always_ff @(posedge clk) begin
		if (sample)
			rdata <= lcd_data_in;
	end

	assign busy      = (state_q != WAIT_CFG) && (state_q != IDLE);
	assign init_done = (state_q == IDLE) || (state_q == CMD);

	a_idle_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(state_q == IDLE) && empty && !init_start |=> state_q == IDLE);

	a_e_window: assert property (@(posedge clk) disable iff (!arst_n)
		pins.e |-> state_q inside {INIT, CMD});

endmodule

`default_nettype wire

// ==== verilog/lcd_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_ctrl_top
	import lcd_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        arst_n,
	input  wire logic [3:0]  paddr,
	input  wire logic        psel,
	input  wire logic        penable,
	input  wire logic        pwrite,
	input  wire logic [31:0] pwdata,
	output logic      [31:0] prdata,
	output logic             pready,
	output logic             pslverr,
	output logic             lcd_e,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic      [7:0]  lcd_data,
	input  wire logic [7:0]  lcd_data_in
);

	lcd_init_cfg_t        init_cfg;
	logic                 init_start;
	logic                 push;
	lcd_cmd_t             push_data;
	logic                 pop;
	lcd_cmd_t             head;
	logic                 fifo_empty;
	logic                 fifo_full;
	logic [LCD_LVL_W-1:0] fifo_level;
	logic                 busy;
	logic                 init_done;
	logic                 rdata_valid;
	logic [7:0]           rdata;
	lcd_pins_t            pins;

	lcd_apb_regs regs_i (
		.clk(clk), .arst_n(arst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.init_cfg(init_cfg), .init_start(init_start),
		.push(push), .push_data(push_data),
		.fifo_full(fifo_full), .fifo_level(fifo_level),
		.busy(busy), .init_done(init_done),
		.rdata_valid(rdata_valid), .rdata(rdata)
	);

	lcd_cmd_fifo #(.DEPTH(`LCD_FIFO_DEPTH)) fifo_i (
		.clk(clk), .arst_n(arst_n),
		.push(push), .push_data(push_data), .pop(pop),
		.head(head), .empty(fifo_empty), .full(fifo_full), .level(fifo_level)
	);

	lcd_timing_engine engine_i (
		.clk(clk), .arst_n(arst_n),
		.init_cfg(init_cfg), .init_start(init_start),
		.empty(fifo_empty), .pop(pop), .head(head),
		.pins(pins), .lcd_data_in(lcd_data_in),
		.busy(busy), .init_done(init_done),
		.rdata_valid(rdata_valid), .rdata(rdata)
	);

	// panel pins
	assign lcd_e    = pins.e;
	assign lcd_rs   = pins.rs;
	assign lcd_rw   = pins.rw;
	assign lcd_data = pins.data;

endmodule

`default_nettype wire

// ==== verif/lcd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_tb
	import lcd_pkg::*;
();

	localparam int T           = `LCD_CLK_PER_US;
	localparam int DEPTH       = `LCD_FIFO_DEPTH;
	localparam int INIT_W      = `LCD_STEP_PULSE_US * T;	// e high per init step
	localparam int CMD_W       = (`LCD_E_FALL_US - `LCD_E_RISE_US) * T;
	// ~19000 cycles of power-up and init plus ~20 slots of 1001 cycles, with margin
	localparam int TIMEOUT_CYC = 60000;

	logic        clk;
	logic        arst_n;
	logic [3:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        lcd_e;
	logic        lcd_rs;
	logic        lcd_rw;
	logic [7:0]  lcd_data;
	logic [7:0]  lcd_data_in;

	integer      seed = 60;
	int          cycle_cnt;
	lcd_cmd_t    exp_q[$];	// reference pulses in order
	int          width_q[$];	// expected e-high length per pulse
	lcd_cmd_t    cur;
	int          cur_w;
	int          high_cnt;
	logic        e_prev;
	logic        init_sent;
	logic [7:0]  panel_byte;	// byte the panel presents on reads

	lcd_ctrl_top dut_i (
		.clk(clk), .arst_n(arst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.lcd_e(lcd_e), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_data(lcd_data),
		.lcd_data_in(lcd_data_in)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
	                               input logic [31:0] got);
		$display("FAILED %s: expected 0x%0h, observed 0x%0h", sig, exp, got);
		abort_run();
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		abort_run();
	endtask

	// setup then access phase, zero wait states
	task automatic apb_access(input logic write, input logic [3:0] addr,
	                          input logic [31:0] wdata, output logic [31:0] rdata,
	                          output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		assert (pready == 1'b1) else report_mismatch("pready", 1, pready);
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_status(output lcd_status_t st);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b0, `LCD_ADDR_STATUS, '0, rd, err);
		st = rd[$bits(lcd_status_t)-1:0];
	endtask

	task automatic expect_word(input lcd_cmd_t w, input int width);
		exp_q.push_back(w);
		width_q.push_back(width);
	endtask

	// write one command word, check the response and queue it if it should land
	task automatic queue_cmd(input lcd_cmd_t c, input logic exp_err);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, `LCD_ADDR_CMD, {22'd0, c}, rd, err);
		assert (err == exp_err) else report_mismatch("pslverr", exp_err, err);
		if (!exp_err)
			expect_word(c, CMD_W);
	endtask

	task automatic wait_idle();
		lcd_status_t st;
		do
			read_status(st);
		while (st.busy || !st.fifo_empty);
		assert (exp_q.size() == 0) else report_problem("expected enable pulses never appeared");
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC)
			report_problem("timeout: the run did not finish within the cycle limit");
	end

	always @(posedge clk)
		lcd_data_in <= panel_byte;

	// panel model, samples pins mid-cycle
	always @(negedge clk) begin
		if (arst_n) begin
			if (!init_sent)
				assert ({lcd_e, lcd_rs, lcd_rw, lcd_data} == 11'd0)
				else report_mismatch("{lcd_e,lcd_rs,lcd_rw,lcd_data}", 0,
				                     {lcd_e, lcd_rs, lcd_rw, lcd_data});
			if (lcd_e && !e_prev) begin
				assert (exp_q.size() > 0) else report_problem("enable pulse with no word expected");
				cur      = exp_q.pop_front();
				cur_w    = width_q.pop_front();
				high_cnt = 0;
				if (lcd_rw)
					panel_byte = 8'($random(seed));	// new byte per read slot
			end
			if (lcd_e) begin
				high_cnt++;
				assert (lcd_rs == cur.rs) else report_mismatch("lcd_rs", cur.rs, lcd_rs);
				assert (lcd_rw == cur.rw) else report_mismatch("lcd_rw", cur.rw, lcd_rw);
				assert (lcd_data == cur.data) else report_mismatch("lcd_data", cur.data, lcd_data);
			end else if (e_prev) begin
				assert (high_cnt == cur_w) else report_mismatch("lcd_e high cycles", cur_w, high_cnt);
			end
			e_prev = lcd_e;
		end
	end

	initial begin
		logic [31:0]   rd;
		logic          err;
		lcd_status_t   st;
		lcd_init_cfg_t cfg;
		lcd_cmd_t      c;
		int            i;

		arst_n     = 1'b0;
		paddr      = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		lcd_data_in = '0;
		panel_byte = '0;
		cycle_cnt  = 0;
		e_prev     = 1'b0;
		init_sent  = 1'b0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		read_status(st);	// still in power-up
		assert (st.busy == 1'b1) else report_mismatch("status.busy", 1, st.busy);
		assert (st.init_done == 1'b0) else report_mismatch("status.init_done", 0, st.init_done);

		cfg = lcd_init_cfg_t'(7'($random(seed)));
		expect_word({2'b00, 8'('h30 + cfg.lines * 8 + cfg.font * 4)}, INIT_W);
		expect_word({2'b00, 8'('h08 + cfg.display_on * 4 + cfg.cursor * 2 + cfg.blink)}, INIT_W);
		expect_word({2'b00, 8'h01}, INIT_W);
		expect_word({2'b00, 8'('h04 + cfg.inc_dec * 2 + cfg.shift)}, INIT_W);
		for (i = 0; i < 2; i++) begin	// parked in the FIFO until init ends
			c    = lcd_cmd_t'($random(seed));
			c.rw = 1'b0;
			queue_cmd(c, 1'b0);
		end
		do
			read_status(st);
		while (st.busy);
		init_sent = 1'b1;
		apb_access(1'b1, `LCD_ADDR_CTRL, {25'd0, cfg}, rd, err);
		assert (err == 1'b0) else report_mismatch("pslverr", 0, err);
		wait_idle();
		read_status(st);
		assert (st.init_done == 1'b1) else report_mismatch("status.init_done", 1, st.init_done);

		for (i = 0; i < 3; i++) begin
			c    = lcd_cmd_t'($random(seed));
			c.rw = 1'b0;
			queue_cmd(c, 1'b0);
		end
		wait_idle();

		// first word is popped at once, the next DEPTH fill the FIFO
		for (i = 0; i < DEPTH + 3; i++) begin
			c    = lcd_cmd_t'($random(seed));
			c.rw = 1'b0;
			queue_cmd(c, i >= DEPTH + 1);
		end
		read_status(st);
		assert (st.overflow == 1'b1) else report_mismatch("status.overflow", 1, st.overflow);
		assert (st.level == DEPTH) else report_mismatch("status.level", DEPTH, st.level);
		read_status(st);
		assert (st.overflow == 1'b0) else report_mismatch("status.overflow", 0, st.overflow);
		wait_idle();

		c    = lcd_cmd_t'($random(seed));
		c.rw = 1'b1;
		queue_cmd(c, 1'b0);
		wait_idle();
		apb_access(1'b0, `LCD_ADDR_RDATA, '0, rd, err);
		assert (rd[7:0] == panel_byte) else report_mismatch("rdata", panel_byte, rd[7:0]);

		apb_access(1'b0, 4'h2, '0, rd, err);
		assert (err == 1'b1) else report_mismatch("pslverr", 1, err);
		apb_access(1'b1, 4'hA, 32'h5A, rd, err);
		assert (err == 1'b1) else report_mismatch("pslverr", 1, err);

		c    = lcd_cmd_t'($random(seed));
		c.rw = 1'b0;
		queue_cmd(c, 1'b0);
		while (!lcd_e)
			@(negedge clk);
		apb_access(1'b1, `LCD_ADDR_CTRL, {25'd0, ~cfg}, rd, err);	// engine mid-slot
		assert (err == 1'b1) else report_mismatch("pslverr", 1, err);
		wait_idle();
		read_status(st);
		assert (st.init_done == 1'b1) else report_mismatch("status.init_done", 1, st.init_done);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/lcd_pkg.sv
verilog/lcd_cmd_fifo.sv
verilog/lcd_apb_regs.sv
verilog/lcd_timing_engine.sv
verilog/lcd_ctrl_top.sv
verif/lcd_tb.sv
